/* project.f */
rtl/img_geom_pkg.sv
rtl/apb_map_pkg.sv
rtl/frame_ram.sv
rtl/host_regs.sv
rtl/phase_fsm.sv
rtl/raster_scan.sv
rtl/blur_window.sv
rtl/keypoint_detect.sv
rtl/sift_core.sv
verif/tb_sift_core.sv

/* rtl/apb_map_pkg.sv */
package apb_map_pkg;

    localparam int APB_AW = 12;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_s;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_s;

    localparam logic [APB_AW-1:0] REG_CTRL   = 12'h000;    // bit 0 starts a run
    localparam logic [APB_AW-1:0] REG_STATUS = 12'h004;    // {done, busy}
    localparam logic [APB_AW-1:0] REG_THRESH = 12'h008;
    localparam logic [APB_AW-1:0] REG_KCOUNT = 12'h00C;

    // top two address bits pick the window, one word per entry
    localparam logic [APB_AW-1:0] WIN_IMG    = 12'h400;
    localparam logic [APB_AW-1:0] WIN_BLUR   = 12'h800;
    localparam logic [APB_AW-1:0] WIN_KPT    = 12'hC00;

endpackage

/* rtl/blur_window.sv */
`timescale 1ns/1ps

module blur_window (
    input  logic                   clk,
    input  logic                   rst_n,
    input  img_geom_pkg::phase_e   phase,
    input  img_geom_pkg::pix_idx_t wr_idx,
    input  logic                   wr_en,
    input  img_geom_pkg::pixel_t   pix_in,
    output logic                   blur_we,
    output img_geom_pkg::pixel_t   blur_data
);
    import img_geom_pkg::*;

    pixel_t           line0_q [IMG_W];          // 1..16 pixels behind pix_in
    pixel_t           line1_q [IMG_W];          // 17..32 behind
    pixel_t           tail_q  [2];
    pixel_t           win     [3][3];           // [row][col], centre at [1][1]
    pix_pos_s         ctr;
    logic             stream_q;
    logic [PIX_W+3:0] acc;

    always_ff @(posedge clk) begin
        if (!rst_n)
            stream_q <= 1'b0;
        else
            stream_q <= (phase == PH_BLUR);     // pix_in holds blur-phase reads
    end

    always_ff @(posedge clk) begin
        if (stream_q) begin
            line0_q[0] <= pix_in;
            line1_q[0] <= line0_q[IMG_W-1];
            for (int k = 1; k < IMG_W; k++) begin
                line0_q[k] <= line0_q[k-1];
                line1_q[k] <= line1_q[k-1];
            end
            tail_q[0] <= line1_q[IMG_W-1];
            tail_q[1] <= tail_q[0];
        end
    end

    assign ctr = pix_pos_s'(wr_idx);

    always_comb begin
        win[0] = '{tail_q[1], tail_q[0], line1_q[IMG_W-1]};
        win[1] = '{line1_q[1], line1_q[0], line0_q[IMG_W-1]};
        win[2] = '{line0_q[1], line0_q[0], pix_in};
        acc    = '0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                // zero padding outside the frame
                if (!((i == 0 && ctr.row == 0) || (i == 2 && ctr.row == IMG_H - 1) ||
                      (j == 0 && ctr.col == 0) || (j == 2 && ctr.col == IMG_W - 1)))
                    acc = acc + ((PIX_W+4)'(win[i][j]) << (int'(i == 1) + int'(j == 1)));
            end
        end
    end

    assign blur_we   = wr_en && (phase == PH_BLUR);
    assign blur_data = pixel_t'(acc >> 4);      // /16, truncated

endmodule

/* rtl/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram #(
    parameter int DW    = 8,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic [DW-1:0]            wdata,
    output logic [DW-1:0]            rdata
);

    logic [DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr];                    // data one cycle after address
    end

endmodule

/* rtl/host_regs.sv */
`timescale 1ns/1ps

module host_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  apb_map_pkg::apb_req_s    req,
    output apb_map_pkg::apb_rsp_s    rsp,
    input  img_geom_pkg::phase_e     phase,
    input  img_geom_pkg::kpt_count_t kpt_count,
    input  img_geom_pkg::pix_idx_t   eng_rd_idx,
    output logic                     start,
    output img_geom_pkg::pixel_t     thresh,
    output logic                     img_we,
    output img_geom_pkg::pix_idx_t   img_waddr,
    output img_geom_pkg::pixel_t     img_wdata,
    output img_geom_pkg::pix_idx_t   img_raddr,
    output img_geom_pkg::pix_idx_t   blur_raddr,
    output img_geom_pkg::pix_idx_t   kpt_raddr,
    input  img_geom_pkg::pixel_t     img_rdata,
    input  img_geom_pkg::pixel_t     blur_rdata,
    input  img_geom_pkg::pix_idx_t   kpt_rdata
);
    import img_geom_pkg::*;
    import apb_map_pkg::*;

    logic        access, busy, start_req, err, win_rd, wait_q;
    logic        is_reg, is_img, is_blur, is_kpt, reg_hit, ro_write;
    logic [1:0]  region;
    pix_idx_t    host_idx;
    pixel_t      thresh_q;
    logic [31:0] rdata;

    assign access   = req.psel && req.penable;
    assign busy     = (phase == PH_BLUR) || (phase == PH_DETECT);
    assign region   = req.paddr[APB_AW-1 -: 2];
    assign host_idx = req.paddr[IDX_W+1:2];               // word stride
    assign is_reg   = region == REG_CTRL[APB_AW-1 -: 2];
    assign is_img   = region == WIN_IMG[APB_AW-1 -: 2];
    assign is_blur  = region == WIN_BLUR[APB_AW-1 -: 2];
    assign is_kpt   = region == WIN_KPT[APB_AW-1 -: 2];
    assign reg_hit  = req.paddr inside {REG_CTRL, REG_STATUS, REG_THRESH, REG_KCOUNT};

    assign ro_write  = req.pwrite && (req.paddr == REG_STATUS || req.paddr == REG_KCOUNT ||
                                      is_blur || is_kpt);
    assign start_req = req.pwrite && (req.paddr == REG_CTRL) && req.pwdata[0];
    assign err       = (is_reg && !reg_hit) || ro_write || (busy && !is_reg) ||
                       (busy && start_req);
    assign win_rd    = !req.pwrite && !is_reg && !err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_q   <= 1'b0;
            thresh_q <= '0;
        end else begin
            wait_q <= access && win_rd && !wait_q;     // one wait state for the RAM
            if (access && req.pwrite && req.paddr == REG_THRESH)
                thresh_q <= req.pwdata[PIX_W-1:0];
        end
    end

    always_comb begin
        rdata = '0;
        if (is_img)
            rdata[PIX_W-1:0] = img_rdata;
        else if (is_blur)
            rdata[PIX_W-1:0] = blur_rdata;
        else if (is_kpt)
            rdata[IDX_W-1:0] = kpt_rdata;
        else if (req.paddr == REG_STATUS)
            rdata[1:0] = {phase == PH_DONE, busy};
        else if (req.paddr == REG_THRESH)
            rdata[PIX_W-1:0] = thresh_q;
        else if (req.paddr == REG_KCOUNT)
            rdata[$bits(kpt_count_t)-1:0] = kpt_count;
    end

    always_comb begin
        rsp.pready  = access && (!win_rd || wait_q);
        rsp.pslverr = access && err;
        rsp.prdata  = rdata;
    end

    assign start      = access && start_req && !err;
    assign thresh     = thresh_q;
    assign img_we     = access && req.pwrite && is_img && !err;
    assign img_waddr  = host_idx;
    assign img_wdata  = req.pwdata[PIX_W-1:0];
    assign img_raddr  = busy ? eng_rd_idx : host_idx;    // engine owns reads during a run
    assign blur_raddr = busy ? eng_rd_idx : host_idx;
    assign kpt_raddr  = host_idx;

    ap_pready_single: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.pready |=> !rsp.pready);

endmodule

/* rtl/img_geom_pkg.sv */
package img_geom_pkg;

    localparam int IMG_W     = 16;
    localparam int IMG_H     = 16;
    localparam int PIX_W     = 8;
    localparam int NPIX      = IMG_W * IMG_H;
    localparam int IDX_W     = 8;
    localparam int KPT_DEPTH = 256;
    localparam int SCAN_LAG  = IMG_W + 1;       // newest window pixel to centre

    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic [IDX_W-1:0] pix_idx_t;
    typedef logic [IDX_W:0]   kpt_count_t;      // room for a full 256

    typedef struct packed {
        logic [$clog2(IMG_H)-1:0] row;
        logic [$clog2(IMG_W)-1:0] col;
    } pix_pos_s;

    typedef union packed {
        pix_idx_t idx;                          // raster index
        pix_pos_s pos;
    } kpt_entry_u;

    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_BLUR   = 2'd1,
        PH_DETECT = 2'd2,
        PH_DONE   = 2'd3
    } phase_e;

endpackage

/* rtl/keypoint_detect.sv */
`timescale 1ns/1ps

module keypoint_detect (
    input  logic                     clk,
    input  logic                     rst_n,
    input  img_geom_pkg::phase_e     phase,
    input  logic                     wr_en,
    input  img_geom_pkg::pix_idx_t   wr_idx,
    input  img_geom_pkg::pixel_t     img_pix,
    input  img_geom_pkg::pixel_t     blur_pix,
    input  img_geom_pkg::pixel_t     thresh,
    output logic                     kpt_we,
    output img_geom_pkg::pix_idx_t   kpt_addr,
    output img_geom_pkg::kpt_entry_u kpt_data,
    output img_geom_pkg::kpt_count_t kpt_count
);
    import img_geom_pkg::*;

    pixel_t     diff;
    kpt_count_t count_q;

    assign diff   = (img_pix > blur_pix) ? img_pix - blur_pix : blur_pix - img_pix;
    assign kpt_we = (phase == PH_DETECT) && wr_en && (diff > thresh);

    always_ff @(posedge clk) begin
        if (!rst_n)
            count_q <= '0;
        else if (phase == PH_BLUR)
            count_q <= '0;                      // fresh run
        else if (kpt_we)
            count_q <= count_q + 1'b1;
    end

    always_comb begin
        kpt_data.idx = wr_idx;
    end

    assign kpt_addr  = count_q[IDX_W-1:0];      // next free slot
    assign kpt_count = count_q;

    ap_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= kpt_count_t'(KPT_DEPTH));

endmodule

/* rtl/phase_fsm.sv */
`timescale 1ns/1ps

module phase_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 scan_end,
    output img_geom_pkg::phase_e phase
);
    import img_geom_pkg::*;

    phase_e state_q;
    phase_e state_nx;

    always_ff @(posedge clk) begin
        if (!rst_n)
            state_q <= PH_IDLE;
        else
            state_q <= state_nx;
    end

    always_comb begin
        state_nx = state_q;
        case (state_q)
            PH_IDLE: begin
                if (start)
                    state_nx = PH_BLUR;
            end
            PH_BLUR: begin
                if (scan_end)
                    state_nx = PH_DETECT;
            end
            PH_DETECT: begin
                if (scan_end)
                    state_nx = PH_DONE;
            end
            PH_DONE: begin
                if (start)
                    state_nx = PH_BLUR;         // rerun on the loaded image
            end
            default: state_nx = PH_IDLE;
        endcase
    end

    assign phase = state_q;

    // the scan counter only runs in the two active phases
    ap_scan_end_active: assert property (@(posedge clk) disable iff (!rst_n)
        scan_end |-> state_q inside {PH_BLUR, PH_DETECT});

endmodule

/* rtl/raster_scan.sv */
`timescale 1ns/1ps

module raster_scan (
    input  logic                   clk,
    input  logic                   rst_n,
    input  img_geom_pkg::phase_e   phase,
    output img_geom_pkg::pix_idx_t rd_idx,
    output img_geom_pkg::pix_idx_t wr_idx,
    output logic                   rd_en,
    output logic                   wr_en,
    output logic                   scan_end
);
    import img_geom_pkg::*;

    logic [IDX_W:0] cnt_q;
    logic [IDX_W:0] last;
    logic [IDX_W:0] lag;
    logic           active;

    assign active = (phase == PH_BLUR) || (phase == PH_DETECT);
    assign last   = (phase == PH_BLUR) ? (IDX_W+1)'(NPIX + SCAN_LAG) : (IDX_W+1)'(NPIX);
    assign lag    = (phase == PH_BLUR) ? (IDX_W+1)'(SCAN_LAG + 1) : (IDX_W+1)'(1);

    always_ff @(posedge clk) begin
        if (!rst_n)
            cnt_q <= '0;
        else if (!active || scan_end)
            cnt_q <= '0;                        // restart for the next phase
        else
            cnt_q <= cnt_q + 1'b1;
    end

    assign scan_end = active && (cnt_q == last);
    assign rd_en    = active && (cnt_q < (IDX_W+1)'(NPIX));
    assign rd_idx   = cnt_q[IDX_W-1:0];
    assign wr_en    = active && (cnt_q >= lag);
    assign wr_idx   = pix_idx_t'(cnt_q - lag);  // blur centre or tested pixel

endmodule

/* rtl/sift_core.sv */
`timescale 1ns/1ps

module sift_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  apb_map_pkg::apb_req_s apb_req,
    output apb_map_pkg::apb_rsp_s apb_rsp
);
    import img_geom_pkg::*;

    phase_e     phase;
    logic       start, scan_end, wr_en;
    pix_idx_t   rd_idx, wr_idx;
    pixel_t     thresh;
    logic       img_we, blur_we, kpt_we;
    pix_idx_t   img_waddr, img_raddr, blur_raddr, kpt_raddr, kpt_addr, kpt_rdata;
    pixel_t     img_wdata, img_rdata, blur_data, blur_rdata;
    kpt_entry_u kpt_data;
    kpt_count_t kpt_count;

    host_regs u_host_regs (
        .clk(clk), .rst_n(rst_n), .req(apb_req), .rsp(apb_rsp),
        .phase(phase), .kpt_count(kpt_count), .eng_rd_idx(rd_idx),
        .start(start), .thresh(thresh),
        .img_we(img_we), .img_waddr(img_waddr), .img_wdata(img_wdata),
        .img_raddr(img_raddr), .blur_raddr(blur_raddr), .kpt_raddr(kpt_raddr),
        .img_rdata(img_rdata), .blur_rdata(blur_rdata), .kpt_rdata(kpt_rdata)
    );

    phase_fsm u_phase_fsm (
        .clk(clk), .rst_n(rst_n), .start(start), .scan_end(scan_end), .phase(phase)
    );

    raster_scan u_raster_scan (
        .clk(clk), .rst_n(rst_n), .phase(phase), .rd_idx(rd_idx), .wr_idx(wr_idx),
        .rd_en(), .wr_en(wr_en), .scan_end(scan_end)
    );

    blur_window u_blur_window (
        .clk(clk), .rst_n(rst_n), .phase(phase), .wr_idx(wr_idx), .wr_en(wr_en),
        .pix_in(img_rdata), .blur_we(blur_we), .blur_data(blur_data)
    );

    keypoint_detect u_keypoint_detect (
        .clk(clk), .rst_n(rst_n), .phase(phase), .wr_en(wr_en), .wr_idx(wr_idx),
        .img_pix(img_rdata), .blur_pix(blur_rdata), .thresh(thresh),
        .kpt_we(kpt_we), .kpt_addr(kpt_addr), .kpt_data(kpt_data), .kpt_count(kpt_count)
    );

    frame_ram #(.DW(PIX_W), .DEPTH(NPIX)) img_ram (
        .clk(clk), .we(img_we), .waddr(img_waddr), .raddr(img_raddr),
        .wdata(img_wdata), .rdata(img_rdata)
    );

    frame_ram #(.DW(PIX_W), .DEPTH(NPIX)) blur_ram (
        .clk(clk), .we(blur_we), .waddr(wr_idx), .raddr(blur_raddr),
        .wdata(blur_data), .rdata(blur_rdata)
    );

    frame_ram #(.DW(IDX_W), .DEPTH(KPT_DEPTH)) kpt_ram (
        .clk(clk), .we(kpt_we), .waddr(kpt_addr), .raddr(kpt_raddr),
        .wdata(kpt_data), .rdata(kpt_rdata)
    );

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_sift_core \
    -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_sift_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
fi
exit 1

/* verif/tb_sift_core.sv */
`timescale 1ns/1ps

module tb_sift_core;
    import img_geom_pkg::*;
    import apb_map_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_CYCLES = 20000;              // two runs plus about 3000 transfers

    logic        clk;
    logic        rst_n;
    apb_req_s    apb_req;
    apb_rsp_s    apb_rsp;
    int          cycles = 0;
    logic [31:0] lcg_state;
    pixel_t      image[];
    pixel_t      blur_ref[];

    sift_core UUT (.clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        $display("Done: errors found");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_plain(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // one transfer: setup, then access until pready; ends 2 ns after a rising edge
    task automatic apb_xfer(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr, output int waits);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(negedge clk);
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic write_ok(input logic [APB_AW-1:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_xfer(1'b1, addr, data, rd, err, waits);
        assert (!err && waits == 0)
            else report_plain($sformatf("write to 0x%0h not completed cleanly", addr));
    endtask

    task automatic read_ok(input logic [APB_AW-1:0] addr, output logic [31:0] data);
        logic err;
        int   waits;
        int   exp_waits;
        exp_waits = (addr >= WIN_IMG) ? 1 : 0;      // windows add one RAM cycle
        apb_xfer(1'b0, addr, 32'h0, data, err, waits);
        assert (!err) else report_plain($sformatf("read of 0x%0h gave pslverr", addr));
        assert (waits == exp_waits)
            else report_mismatch("read wait states", 32'(waits), 32'(exp_waits));
    endtask

    task automatic check_read(input logic [APB_AW-1:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] got;
        read_ok(addr, got);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    task automatic expect_error(input logic write, input logic [APB_AW-1:0] addr,
                                input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_xfer(write, addr, data, rd, err, waits);
        assert (err) else report_plain($sformatf("access to 0x%0h gave no pslverr", addr));
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[1])
            read_ok(REG_STATUS, st);
        assert (st == 32'd2) else report_mismatch("STATUS", st, 32'd2);
    endtask

    // 1-2-1 by 1-2-1, zero outside the frame, sum / 16
    task automatic build_blur_ref();
        int acc;
        int r;
        int c;
        int w;
        for (int idx = 0; idx < NPIX; idx++) begin
            acc = 0;
            for (int dr = -1; dr <= 1; dr++) begin
                for (int dc = -1; dc <= 1; dc++) begin
                    r = idx / IMG_W + dr;
                    c = idx % IMG_W + dc;
                    w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
                    if (r >= 0 && r < IMG_H && c >= 0 && c < IMG_W)
                        acc += w * int'(image[r * IMG_W + c]);
                end
            end
            blur_ref[idx] = pixel_t'(acc / 16);
        end
    endtask

    task automatic check_keypoints(input int thr);
        logic [31:0] rd;
        kpt_entry_u  ent;
        int          diff;
        int          exp_idx[$];
        for (int i = 0; i < NPIX; i++) begin
            diff = int'(image[i]) - int'(blur_ref[i]);
            if (diff < 0)
                diff = -diff;
            if (diff > thr)
                exp_idx.push_back(i);
        end
        check_read(REG_KCOUNT, 32'(exp_idx.size()), "KCOUNT");
        for (int k = 0; k < exp_idx.size(); k++) begin
            read_ok(WIN_KPT + APB_AW'(4 * k), rd);
            ent = kpt_entry_u'(rd[IDX_W-1:0]);
            assert (int'(ent.idx) == exp_idx[k])
                else report_mismatch($sformatf("WIN_KPT[%0d].idx", k), 32'(ent.idx),
                                     32'(exp_idx[k]));
            assert (int'(ent.pos.row) == exp_idx[k] / IMG_W)
                else report_mismatch($sformatf("WIN_KPT[%0d].row", k), 32'(ent.pos.row),
                                     32'(exp_idx[k] / IMG_W));
            assert (int'(ent.pos.col) == exp_idx[k] % IMG_W)
                else report_mismatch($sformatf("WIN_KPT[%0d].col", k), 32'(ent.pos.col),
                                     32'(exp_idx[k] % IMG_W));
        end
    endtask

    ap_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !apb_req.psel |-> !apb_rsp.pready && !apb_rsp.pslverr)
        else report_plain("response driven while psel is low");

    ap_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pready |-> apb_req.psel && apb_req.penable)
        else report_plain("pready outside the access phase");

    ap_start_to_blur: assert property (@(posedge clk) disable iff (!rst_n)
        UUT.start |=> UUT.phase == PH_BLUR)
        else report_plain("blur phase not entered the cycle after start");

    ap_detect_to_done: assert property (@(posedge clk) disable iff (!rst_n)
        UUT.phase == PH_DETECT && UUT.scan_end |=> UUT.phase == PH_DONE)
        else report_plain("done phase not entered after the detect scan");

    initial begin
        rst_n     = 1'b0;
        apb_req   = '0;
        lcg_state = 32'd93360;
        image     = new[NPIX];
        blur_ref  = new[NPIX];
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        check_read(REG_STATUS, 32'd0, "STATUS");
        check_read(REG_KCOUNT, 32'd0, "KCOUNT");
        check_read(REG_THRESH, 32'd0, "THRESH");

        for (int i = 0; i < NPIX; i++) begin
            lcg_state = lcg_next(lcg_state);
            image[i]  = lcg_state[23:16];           // upper bits, better spread
            write_ok(WIN_IMG + APB_AW'(4 * i), 32'(image[i]));
        end
        for (int i = 0; i < NPIX; i++)
            check_read(WIN_IMG + APB_AW'(4 * i), 32'(image[i]), $sformatf("WIN_IMG[%0d]", i));
        build_blur_ref();

        // first run, with rejected accesses while busy
        write_ok(REG_THRESH, 32'd40);
        check_read(REG_THRESH, 32'd40, "THRESH");
        write_ok(REG_CTRL, 32'd1);
        check_read(REG_STATUS, 32'd1, "STATUS");
        expect_error(1'b0, WIN_IMG, 32'd0);
        expect_error(1'b1, WIN_IMG + 12'd8, 32'hA5);
        expect_error(1'b0, WIN_BLUR, 32'd0);
        expect_error(1'b1, REG_CTRL, 32'd1);
        wait_done();
        for (int i = 0; i < NPIX; i++)
            check_read(WIN_BLUR + APB_AW'(4 * i), 32'(blur_ref[i]),
                       $sformatf("WIN_BLUR[%0d]", i));
        check_keypoints(40);

        // rerun on the same image
        write_ok(REG_THRESH, 32'd90);
        write_ok(REG_CTRL, 32'd1);
        wait_done();
        check_keypoints(90);

        expect_error(1'b0, 12'h010, 32'd0);         // hole in the register block
        expect_error(1'b1, 12'h3FC, 32'd0);
        expect_error(1'b1, WIN_BLUR + 12'd4, 32'd7);
        expect_error(1'b1, REG_KCOUNT, 32'd5);

        $display("Done: no errors");
        $finish;
    end

endmodule
